/* source/qubic_params.svh */
`ifndef QUBIC_PARAMS_SVH
`define QUBIC_PARAMS_SVH

//////////////////////////////////////////////////////////////
// Subsystem sizing
//////////////////////////////////////////////////////////////

// Number of FMC card slots on the carrier
`define QH_N_FMC 2

// ADC sample and DAC word width, two's complement
`define QH_SAMPLE_W 16

// Gain is fixed point, unity = 1 << QH_GAIN_FRAC
`define QH_GAIN_FRAC 12

// Length of the active-low ADC sync pulse, in sysclk cycles
`define QH_SYNC_CYCLES 4

// Clip event counter width, saturates at all ones
`define QH_CLIP_W 8

`endif

/* source/fmc_pkg.sv */
`default_nettype none

`include "qubic_params.svh"

package fmc_pkg;

  // Signed ADC sample / DAC word
  typedef logic signed [`QH_SAMPLE_W-1:0] sample_t;

  // Selects one card slot
  typedef logic [$clog2(`QH_N_FMC)-1:0] card_idx_t;

  // Saturating clip count
  typedef logic [`QH_CLIP_W-1:0] clip_cnt_t;

  // Per-card datapath settings
  typedef struct packed {
    sample_t gain;    // Q(SAMPLE_W-GAIN_FRAC).GAIN_FRAC
    sample_t offset;  // Added after scaling
    logic    enable;  // Samples dropped when low
  } card_cfg_t;

endpackage

`default_nettype wire

/* source/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;
  import fmc_pkg::*;

  // Register field within one card
  typedef enum logic [1:0] {
    FIELD_GAIN   = 2'd0,
    FIELD_OFFSET = 2'd1,
    FIELD_ENABLE = 2'd2,  // Data bit 0 only
    FIELD_SYNC   = 2'd3   // Strobe, no storage
  } cfg_field_e;

  // Config address, card in the upper bits
  typedef struct packed {
    card_idx_t  card;
    cfg_field_e field;
  } cfg_addr_t;

endpackage

`default_nettype wire

/* source/fmc_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////
// Decoder to card path settings
//////////////////////////////////////////////////////////////

interface card_cfg_if
  import fmc_pkg::*;
();
  card_cfg_t cfg;       // Levels, held until rewritten
  logic      sync_req;  // Single cycle pulse

  modport ctrl (output cfg, sync_req);
  modport card (input cfg, sync_req);
endinterface

//////////////////////////////////////////////////////////////
// Card path to output stage
//////////////////////////////////////////////////////////////

interface card_out_if
  import fmc_pkg::*;
();
  logic    valid;  // One-cycle strobe per word
  sample_t word;   // Saturated DAC word
  logic    clip;   // Qualified by valid

  modport path (output valid, word, clip);
  modport sink (input valid, word, clip);
endinterface

`default_nettype wire

/* source/cfg_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "qubic_params.svh"

module cfg_decoder
  import fmc_pkg::*;
  import ctrl_pkg::*;
(
  input  logic            sysclk,
  input  logic            arst_n,
  input  logic            cfg_we,
  input  cfg_addr_t       cfg_addr,
  input  sample_t         cfg_data,
  card_cfg_if.ctrl        cards [`QH_N_FMC]
);

  // One settings register per slot
  for (genvar i = 0; i < `QH_N_FMC; i++) begin : g_card
    card_cfg_t cfg_q;
    logic      sync_q;
    logic      hit;

    assign hit = cfg_we && (cfg_addr.card == card_idx_t'(i));  // Write aimed here

    always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
        cfg_q.gain   <= sample_t'(1 << `QH_GAIN_FRAC);  // Unity
        cfg_q.offset <= '0;
        cfg_q.enable <= 1'b0;                           // Card starts muted
        sync_q       <= 1'b0;
      end else begin
        sync_q <= 1'b0;  // Pulse lasts one cycle
        if (hit) begin
          case (cfg_addr.field)
            FIELD_GAIN:   cfg_q.gain   <= cfg_data;
            FIELD_OFFSET: cfg_q.offset <= cfg_data;
            FIELD_ENABLE: cfg_q.enable <= cfg_data[0];
            FIELD_SYNC:   sync_q       <= 1'b1;  // Settings untouched
          endcase
        end
      end
    end

    assign cards[i].cfg      = cfg_q;
    assign cards[i].sync_req = sync_q;
  end

endmodule

`default_nettype wire

/* source/fmc_card_path.sv */
`timescale 1ns/100ps
`default_nettype none

`include "qubic_params.svh"

module fmc_card_path
  import fmc_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  input  logic       adc_valid,
  input  sample_t    adc_sample,
  output logic       adc_sync_n,
  card_cfg_if.card   cfg,
  card_out_if.path   out
);

  localparam int PROD_W   = 2 * `QH_SAMPLE_W;
  localparam int SCALED_W = PROD_W - `QH_GAIN_FRAC;  // Product after the shift
  localparam int SUM_W    = SCALED_W + 1;            // Room for offset carry
  localparam int CNT_W    = $clog2(`QH_SYNC_CYCLES + 1);

  localparam logic signed [SUM_W-1:0] SAT_MAX = (1 <<< (`QH_SAMPLE_W - 1)) - 1;
  localparam logic signed [SUM_W-1:0] SAT_MIN = -(1 <<< (`QH_SAMPLE_W - 1));

  logic signed [PROD_W-1:0]   product;
  logic signed [SCALED_W-1:0] scaled_q;
  logic                       s1_valid_q;
  logic signed [SUM_W-1:0]    sum;
  logic                       sat_hi;
  logic                       sat_lo;
  logic [CNT_W-1:0]           sync_cnt_q;

  //////////////////////////////////////////////////////////////
  // Stage 1, scale by gain
  //////////////////////////////////////////////////////////////

  assign product = adc_sample * cfg.cfg.gain;  // Full precision, signed

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) s1_valid_q <= 1'b0;
    else         s1_valid_q <= adc_valid && cfg.cfg.enable;  // Drop when disabled
  end

  // Top slice equals arithmetic shift right by GAIN_FRAC
  always_ff @(posedge sysclk) begin
    scaled_q <= product[PROD_W-1:`QH_GAIN_FRAC];
  end

  //////////////////////////////////////////////////////////////
  // Stage 2, offset and saturate
  //////////////////////////////////////////////////////////////

  assign sum    = scaled_q + cfg.cfg.offset;  // Sign extended to SUM_W
  assign sat_hi = (sum > SAT_MAX);
  assign sat_lo = (sum < SAT_MIN);

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      out.valid <= 1'b0;
      out.clip  <= 1'b0;
    end else begin
      out.valid <= s1_valid_q;
      out.clip  <= s1_valid_q && (sat_hi || sat_lo);  // Saturation event
    end
  end

  always_ff @(posedge sysclk) begin
    if (sat_hi)      out.word <= SAT_MAX[`QH_SAMPLE_W-1:0];
    else if (sat_lo) out.word <= SAT_MIN[`QH_SAMPLE_W-1:0];
    else             out.word <= sum[`QH_SAMPLE_W-1:0];
  end

  //////////////////////////////////////////////////////////////
  // ADC sync pulse
  //////////////////////////////////////////////////////////////

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      sync_cnt_q <= '0;
      adc_sync_n <= 1'b1;  // Idle high
    end else if (cfg.sync_req) begin
      sync_cnt_q <= CNT_W'(`QH_SYNC_CYCLES - 1);
      adc_sync_n <= 1'b0;
    end else if (sync_cnt_q != '0) begin
      sync_cnt_q <= sync_cnt_q - 1'b1;  // Hold low
    end else begin
      adc_sync_n <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/dac_output_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "qubic_params.svh"

module dac_output_stage
  import fmc_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  card_out_if.sink   paths      [`QH_N_FMC],
  output logic       dac_valid  [`QH_N_FMC],
  output sample_t    dac_word   [`QH_N_FMC],
  output clip_cnt_t  clip_count [`QH_N_FMC]
);

  for (genvar i = 0; i < `QH_N_FMC; i++) begin : g_card
    logic      valid_q;
    sample_t   word_q;
    clip_cnt_t clip_q;

    // Retime toward the DAC lanes
    always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) valid_q <= 1'b0;
      else         valid_q <= paths[i].valid;
    end

    always_ff @(posedge sysclk) begin
      word_q <= paths[i].word;
    end

    // Clip events, stick at max
    always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
        clip_q <= '0;
      end else if (paths[i].valid && paths[i].clip && (clip_q != '1)) begin
        clip_q <= clip_q + 1'b1;
      end
    end

    assign dac_valid[i]  = valid_q;
    assign dac_word[i]   = word_q;
    assign clip_count[i] = clip_q;
  end

endmodule

`default_nettype wire

/* source/qubic_hw.sv */
`timescale 1ns/100ps
`default_nettype none

`include "qubic_params.svh"

module qubic_hw
  import fmc_pkg::*;
  import ctrl_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  // Register writes
  input  logic       cfg_we,
  input  cfg_addr_t  cfg_addr,
  input  sample_t    cfg_data,
  // ADC side, one entry per FMC slot
  input  logic       adc_valid  [`QH_N_FMC],
  input  sample_t    adc_sample [`QH_N_FMC],
  output logic       adc_sync_n [`QH_N_FMC],
  // DAC side
  output logic       dac_valid  [`QH_N_FMC],
  output sample_t    dac_word   [`QH_N_FMC],
  output clip_cnt_t  clip_count [`QH_N_FMC]
);

  card_cfg_if cfg_bus [`QH_N_FMC] ();  // Decoder to paths
  card_out_if out_bus [`QH_N_FMC] ();  // Paths to output stage

  //////////////////////////////////////////////////////////////
  // Settings
  //////////////////////////////////////////////////////////////

  cfg_decoder u_cfg_decoder (
    .sysclk   (sysclk),
    .arst_n   (arst_n),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_data (cfg_data),
    .cards    (cfg_bus)
  );

  //////////////////////////////////////////////////////////////
  // One path per FMC slot
  //////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `QH_N_FMC; i++) begin : g_card
    fmc_card_path u_path (
      .sysclk     (sysclk),
      .arst_n     (arst_n),
      .adc_valid  (adc_valid[i]),
      .adc_sample (adc_sample[i]),
      .adc_sync_n (adc_sync_n[i]),
      .cfg        (cfg_bus[i]),
      .out        (out_bus[i])
    );
  end

  dac_output_stage u_dac_output_stage (
    .sysclk     (sysclk),
    .arst_n     (arst_n),
    .paths      (out_bus),
    .dac_valid  (dac_valid),
    .dac_word   (dac_word),
    .clip_count (clip_count)  // Saturating, per card
  );

endmodule

`default_nettype wire

/* tb/qubic_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "qubic_params.svh"

module qubic_checker
  import fmc_pkg::*;
  import ctrl_pkg::*;
(
  input logic      sysclk,
  input logic      arst_n,
  input logic      cfg_we,
  input cfg_addr_t cfg_addr,
  input sample_t   cfg_data,
  input logic      adc_valid  [`QH_N_FMC],
  input logic      adc_sync_n [`QH_N_FMC],
  input logic      dac_valid  [`QH_N_FMC],
  input clip_cnt_t clip_count [`QH_N_FMC]
);

  for (genvar i = 0; i < `QH_N_FMC; i++) begin : g_card
    logic en_q;  // Shadow of the decoder enable bit

    always_ff @(posedge sysclk or negedge arst_n) begin
      if (!arst_n) begin
        en_q <= 1'b0;
      end else if (cfg_we && cfg_addr.card == card_idx_t'(i) &&
                   cfg_addr.field == FIELD_ENABLE) begin
        en_q <= cfg_data[0];
      end
    end

    // Five low samples in a row is one too many
    a_sync_len: assert property (@(posedge sysclk) disable iff (!arst_n)
      adc_sync_n[i] || $past(adc_sync_n[i], 1) || $past(adc_sync_n[i], 2) ||
      $past(adc_sync_n[i], 3) || $past(adc_sync_n[i], 4))
      else $error("card %0d adc_sync_n low too long", i);

    a_latency: assert property (@(posedge sysclk) disable iff (!arst_n)
      dac_valid[i] == $past(adc_valid[i] && en_q, 3))  // Three register stages
      else $error("card %0d dac_valid not 3 cycles after adc_valid", i);

    a_clip_mono: assert property (@(posedge sysclk) disable iff (!arst_n)
      clip_count[i] >= $past(clip_count[i]))
      else $error("card %0d clip_count went down", i);
  end

endmodule

bind qubic_hw qubic_checker chk_i (
  .sysclk     (sysclk),
  .arst_n     (arst_n),
  .cfg_we     (cfg_we),
  .cfg_addr   (cfg_addr),
  .cfg_data   (cfg_data),
  .adc_valid  (adc_valid),
  .adc_sync_n (adc_sync_n),
  .dac_valid  (dac_valid),
  .clip_count (clip_count)
);

`default_nettype wire

/* tb/tb_qubic_hw.sv */
`timescale 1ns/100ps
`default_nettype none

`include "qubic_params.svh"

module tb_qubic_hw
  import fmc_pkg::*;
  import ctrl_pkg::*;
();

  localparam int     N_REC       = 64;
  localparam int     DRAIN_LIMIT = 20;  // Cycles for the pipeline to empty
  localparam longint W_MAX       = (longint'(1) <<< (`QH_SAMPLE_W - 1)) - 1;
  localparam longint W_MIN       = -(longint'(1) <<< (`QH_SAMPLE_W - 1));

  logic      sysclk;
  logic      arst_n;
  logic      cfg_we;
  cfg_addr_t cfg_addr;
  sample_t   cfg_data;
  logic      adc_valid  [`QH_N_FMC];
  sample_t   adc_sample [`QH_N_FMC];
  logic      adc_sync_n [`QH_N_FMC];
  logic      dac_valid  [`QH_N_FMC];
  sample_t   dac_word   [`QH_N_FMC];
  clip_cnt_t clip_count [`QH_N_FMC];

  logic [43:0] rec_mem [N_REC];           // op, card, field or flag, data, expect
  longint      cyc;
  longint      exp_word_q [`QH_N_FMC][$];  // Words still in flight
  longint      exp_cyc_q  [`QH_N_FMC][$];  // Cycle each one was driven
  longint      gain_m     [`QH_N_FMC];
  longint      offset_m   [`QH_N_FMC];
  bit          enable_m   [`QH_N_FMC];
  int          clips_m    [`QH_N_FMC];

  qubic_hw dut_i (.*);

  initial begin
    sysclk = 1'b0;
    forever #2 sysclk = ~sysclk;
  end

  always @(posedge sysclk) cyc <= cyc + 1;  // Edge count

  //////////////////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////////////////

  // Scale, shift with floor, add offset, clamp
  function automatic longint scale_word(input longint smp, input longint gain,
                                        input longint off, output bit sat);
    longint v;
    v   = ((smp * gain) >>> `QH_GAIN_FRAC) + off;
    sat = (v > W_MAX) || (v < W_MIN);
    if (v > W_MAX)      v = W_MAX;
    else if (v < W_MIN) v = W_MIN;
    return v;
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  // Four-state compare so an unknown output never matches
  task automatic check(input string what, input logic signed [63:0] got,
                       input logic signed [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Wait until every expected word came out
  task automatic drain();
    int n;
    n = 0;
    while (exp_word_q[0].size() + exp_word_q[1].size() != 0) begin
      if (n == DRAIN_LIMIT) abort("timeout waiting for DAC output words");
      n = n + 1;
      @(posedge sysclk);
      #1;
    end
  endtask

  task automatic write_cfg(input int card, input int fld, input logic [15:0] data);
    cfg_addr.card  = card_idx_t'(card);
    cfg_addr.field = cfg_field_e'(fld);
    cfg_data       = data;
    cfg_we         = 1'b1;
    @(posedge sysclk);
    #1;
    cfg_we = 1'b0;
  endtask

  // Low for cycles 1 to 4 after the request edge
  task automatic run_sync(input int card);
    write_cfg(card, FIELD_SYNC, 16'h0000);
    for (int k = 0; k < `QH_SYNC_CYCLES + 2; k++) begin
      check($sformatf("card %0d adc_sync_n", card), adc_sync_n[card],
            (k >= 1 && k <= `QH_SYNC_CYCLES) ? 0 : 1);
      check("other card adc_sync_n", adc_sync_n[card ^ 1], 1);
      @(posedge sysclk);
      #1;
    end
  endtask

  // Output monitor at mid-cycle where outputs are settled
  always @(negedge sysclk) begin
    if (arst_n) begin
      for (int c = 0; c < `QH_N_FMC; c++) begin
        if (dac_valid[c] && exp_word_q[c].size() == 0) begin
          abort($sformatf("card %0d raised dac_valid with no sample pending", c));
        end else if (dac_valid[c]) begin
          check($sformatf("card %0d latency", c), cyc - exp_cyc_q[c][0], 3);
          check($sformatf("card %0d dac_word", c), dac_word[c], exp_word_q[c][0]);
          void'(exp_word_q[c].pop_front());
          void'(exp_cyc_q[c].pop_front());
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Stimulus from the records file
  //////////////////////////////////////////////////////////////

  initial begin
    logic [43:0] r;
    int          op;
    int          card;
    int          fld;
    longint      smp;
    longint      fexp;
    longint      model;
    bit          sat;
    cyc      = 0;
    arst_n   = 1'b0;
    cfg_we   = 1'b0;
    cfg_addr = '0;
    cfg_data = '0;
    for (int c = 0; c < `QH_N_FMC; c++) begin
      adc_valid[c]  = 1'b0;
      adc_sample[c] = '0;
      gain_m[c]     = longint'(1) <<< `QH_GAIN_FRAC;  // Unity after reset
      offset_m[c]   = 0;
      enable_m[c]   = 1'b0;
      clips_m[c]    = 0;
    end
    rec_mem = '{default: '0};  // Op 0 ends the list
    $readmemh("tb/qubic_tests.txt", rec_mem);
    repeat (10) @(posedge sysclk);
    #1 arst_n = 1'b1;
    for (int c = 0; c < `QH_N_FMC; c++) begin
      check("dac_valid after reset", dac_valid[c], 0);
      check("adc_sync_n after reset", adc_sync_n[c], 1);
      check("clip_count after reset", clip_count[c], 0);
    end
    for (int i = 0; i < N_REC && rec_mem[i][43:40] != 0; i++) begin
      r    = rec_mem[i];
      op   = r[43:40];
      card = r[39:36];
      fld  = r[35:32];
      smp  = $signed(r[31:16]);
      fexp = $signed(r[15:0]);
      case (op)
        1: begin
          drain();  // Nothing in flight sees a half-changed setting
          write_cfg(card, fld, r[31:16]);
          if (fld == FIELD_GAIN)   gain_m[card]   = smp;
          if (fld == FIELD_OFFSET) offset_m[card] = smp;
          if (fld == FIELD_ENABLE) enable_m[card] = r[16];
        end
        2: begin
          adc_valid[card]  = 1'b1;
          adc_sample[card] = r[31:16];
          if (enable_m[card]) begin
            model = scale_word(smp, gain_m[card], offset_m[card], sat);
            check("word in tests file", fexp, model);
            exp_word_q[card].push_back(model);
            exp_cyc_q[card].push_back(cyc);
            if (sat) clips_m[card] = clips_m[card] + 1;
          end
          if (!fld[0]) begin  // Flag 1 pairs with the next record
            @(posedge sysclk);
            #1;
            for (int c = 0; c < `QH_N_FMC; c++) adc_valid[c] = 1'b0;
            if (!enable_m[card]) begin
              repeat (6) @(posedge sysclk);  // Window for a stray dac_valid
              #1;
            end
          end
        end
        3: run_sync(card);
        4: begin
          drain();
          check("clip count in tests file", fexp, clips_m[card]);
          check($sformatf("card %0d clip_count", card), clip_count[card], fexp);
        end
        default: abort($sformatf("unknown record type %0d in tests file", op));
      endcase
    end
    drain();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/qubic_tests.txt */
// op_card_field/flag_data_expect; op 1 cfg write, 2 sample, 3 sync, 4 clip count
// sample flag 1 drives together with the next record; clip count sits in expect
2_0_0_1234_0000
1_0_2_0001_0000
2_0_0_1234_1234
2_0_0_ffff_ffff
2_0_0_8000_8000
2_0_0_7fff_7fff
1_0_0_1800_0000
1_0_1_0064_0000
2_0_0_03e8_0640
2_0_0_fc18_fa88
2_0_0_fffd_005f
2_0_0_7530_7fff
2_0_0_8ad0_8000
4_0_0_0000_0002
3_1_0_0000_0000
3_0_0_0000_0000
1_1_2_0001_0000
1_1_0_e000_0000
1_1_1_ff00_0000
1_0_0_0800_0000
1_0_1_0000_0000
2_0_1_0100_0080
2_1_0_0100_fd00
2_0_1_8000_c000
2_1_0_4000_8000
4_1_0_0000_0001
4_0_0_0000_0002

/* tb.f */
+incdir+source
source/fmc_pkg.sv
source/ctrl_pkg.sv
source/fmc_ifs.sv
source/cfg_decoder.sv
source/fmc_card_path.sv
source/dac_output_stage.sv
source/qubic_hw.sv
tb/qubic_checker.sv
tb/tb_qubic_hw.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_qubic_hw -f tb.f &&
./obj_dir/Vtb_qubic_hw || exit 1
